// ==== filelist.f ====
+incdir+source
source/vdec_pkg.sv
source/element_sequencer.sv
source/lane_offset_gen.sv
source/decode_issue_reg.sv
source/vector_decode_stage.sv
sim/vdec_checker.sv
sim/vector_decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the vector decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f filelist.f --top-module vector_decode_stage_tb \
  -o Vvector_decode_stage_tb

# an error stops the run early, the log decides the result
./obj_dir/Vvector_decode_stage_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "All checks passed" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== sim/vdec_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on sequencer credits and handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

module vdec_checker import vdec_pkg::*; (
  input logic       CLK,
  input logic       nRST,
  input seq_state_t state,
  input credit_t    credits,
  input logic       emit,
  input logic       emit_last,
  input logic       flush,
  input logic       credit_return,
  input logic       ready
);
  timeunit 1ns;
  timeprecision 100ps;

  // pairs held by execute, counted from the handshake alone
  int in_flight;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      in_flight <= 0;
    end else if (emit && !credit_return) begin
      in_flight <= in_flight + 1;
    end else if (!emit && credit_return) begin
      in_flight <= in_flight - 1;
    end
  end

  // never more slots than the execute buffer holds
  a_credit_max: assert property (@(posedge CLK) disable iff (!nRST)
    credits <= credit_t'(`VDEC_CREDITS))
    else $error("credit count above the execute buffer depth");

  a_emit_credit: assert property (@(posedge CLK) disable iff (!nRST)
    emit |-> (in_flight < `VDEC_CREDITS))
    else $error("pair emitted with no free credit");

  // no new instruction taken mid sequence
  a_ready_run: assert property (@(posedge CLK) disable iff (!nRST)
    ((state == RUN) && !flush && !(emit && emit_last)) |=> !ready)
    else $error("ready high while the sequencer runs");

endmodule

bind element_sequencer vdec_checker u_chk (
  .CLK(CLK), .nRST(nRST), .state(state), .credits(credits),
  .emit(emit), .emit_last(emit_last), .flush(flush),
  .credit_return(credit_return), .ready(ready)
);

// ==== sim/vector_decode_stage_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector decode stage testbench: instruction table, execute
// credit model, expected pair model and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

module vector_decode_stage_tb import vdec_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] MODE_RUN   = 2'd0;
  localparam logic [1:0] MODE_HOLD  = 2'd1;
  localparam logic [1:0] MODE_FLUSH = 2'd2;

  typedef struct packed {
    offset_t    vl;
    offset_t    vstart;
    vs2_src_t   vs2_src;
    vd_src_t    vd_src;
    word_t      xs1;
    imm5_t      imm5;
    logic       masked;
    word_t      mask_word;
    logic       is_store;
    logic [1:0] mode;
  } entry_t;

  // one issued pair as execute sees it
  typedef struct packed {
    logic                      last;
    logic    [`VDEC_LANES-1:0] wen;
    offset_t [`VDEC_LANES-1:0] wo;
    offset_t [`VDEC_LANES-1:0] vs2;
    offset_t [`VDEC_LANES-1:0] vs1;
  } pair_t;

  logic                      CLK;
  logic                      nRST;
  logic                      flush;
  logic                      start;
  logic                      credit_return = 1'b0;
  offset_t                   vl;
  offset_t                   vstart;
  vs2_src_t                  vs2_src;
  vd_src_t                   vd_src;
  word_t                     xs1;
  imm5_t                     imm5;
  logic                      masked;
  word_t                     mask_word;
  logic                      is_store;
  logic                      ready;
  logic                      issue_valid;
  logic                      issue_last;
  offset_t [`VDEC_LANES-1:0] vs1_offset;
  offset_t [`VDEC_LANES-1:0] vs2_offset;
  offset_t [`VDEC_LANES-1:0] woffset;
  logic    [`VDEC_LANES-1:0] wen;

  entry_t      instr_tbl[$];
  pair_t       exp_q[$];
  pair_t       got_q[$];
  int          credit_due[$];
  int          cycle = 0;
  logic        hold_credits = 1'b0;
  logic        ready_at_last;
  int unsigned seed;

  vector_decode_stage dut (.*);

  always #10 CLK = ~CLK;

  // execute side: take every valid pair, free its slot later
  always @(negedge CLK) begin
    if (nRST && issue_valid) begin
      got_q.push_back(pair_t'({issue_last, wen, woffset, vs2_offset, vs1_offset}));
      credit_due.push_back(cycle + $urandom_range(4, 0));
      if (issue_last) ready_at_last = ready;
    end
  end

  // at most one returned slot per cycle
  always @(posedge CLK) begin
    cycle = cycle + 1;
    #1;
    if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
      credit_return = 1'b1;
      void'(credit_due.pop_front());
    end else begin
      credit_return = 1'b0;
    end
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic add_entry(input int v, input int vs, input vs2_src_t s2, input vd_src_t sd,
                           input word_t x, input int im, input int m, input word_t mw,
                           input int st, input logic [1:0] md);
    entry_t e;
    e.vl        = offset_t'(v);
    e.vstart    = offset_t'(vs);
    e.vs2_src   = s2;
    e.vd_src    = sd;
    e.xs1       = x;
    e.imm5      = imm5_t'(im);
    e.masked    = (m != 0);
    e.mask_word = mw;
    e.is_store  = (st != 0);
    e.mode      = md;
    instr_tbl.push_back(e);
  endtask

  // pairs from the element and offset rules, sums cut to the offset width
  task automatic build_expected(input entry_t t);
    int    n;
    int    k;
    int    i;
    int    e;
    int    s;
    int    w;
    logic  valid;
    logic  mbit;
    pair_t p;
    exp_q.delete();
    if (t.vstart >= t.vl) n = 1;
    else n = (int'(t.vl) - int'(t.vstart) + 1) / 2;
    for (k = 0; k < n; k++) begin
      p = '0;
      p.last = (k == n - 1);
      for (i = 0; i < `VDEC_LANES; i++) begin
        e = int'(t.vstart) + 2 * k + i;
        case (t.vs2_src)
          VS2_SRC_NORMAL:   s = e;
          VS2_SRC_PLUS_XS1: s = e + int'(t.xs1);
          VS2_SRC_PLUS_IMM: s = e + int'(t.imm5);
          VS2_SRC_PLUS_1:   s = e + 1;
          VS2_SRC_MINUS_1:  s = e - 1;
          VS2_SRC_XS1:      s = int'(t.xs1);
          VS2_SRC_IMM:      s = int'(t.imm5);
          default:          s = 0;
        endcase
        case (t.vd_src)
          VD_SRC_NORMAL:   w = e;
          VD_SRC_PLUS_XS1: w = e + int'(t.xs1);
          VD_SRC_PLUS_IMM: w = e + int'(t.imm5);
          VD_SRC_PLUS_1:   w = e + 1;
          default:         w = 0;
        endcase
        valid     = (e < int'(t.vl));
        mbit      = ((t.mask_word >> e) & 32'd1) != 32'd0;
        p.vs1[i]  = offset_t'(e);
        p.vs2[i]  = offset_t'(s);
        p.wo[i]   = offset_t'(w);
        p.wen[i]  = valid && !t.is_store && (!t.masked || mbit);
      end
      exp_q.push_back(p);
    end
  endtask

  task automatic wait_ready();
    int t;
    t = 0;
    while (!ready) begin
      @(posedge CLK);
      #1;
      t++;
      if (t > 100) fail_stop("timeout waiting for the stage to become ready");
    end
  endtask

  task automatic wait_pairs(input int n, input int limit);
    int t;
    t = 0;
    while (got_q.size() < n) begin
      @(posedge CLK);
      #1;
      t++;
      if (t > limit) fail_stop($sformatf("timeout waiting for %0d issued pairs", n));
    end
  endtask

  task automatic drain_credits();
    int t;
    t = 0;
    while (credit_due.size() != 0 || credit_return) begin
      @(posedge CLK);
      #1;
      t++;
      if (t > 100) fail_stop("timeout waiting for execute to return its credits");
    end
  endtask

  task automatic compare_pairs(input int idx, input int n);
    int    k;
    int    i;
    string where;
    for (k = 0; k < n; k++) begin
      for (i = 0; i < `VDEC_LANES; i++) begin
        where = $sformatf("entry %0d pair %0d lane %0d", idx, k, i);
        check_val({where, " vs1_offset"}, 64'(got_q[k].vs1[i]), 64'(exp_q[k].vs1[i]));
        check_val({where, " vs2_offset"}, 64'(got_q[k].vs2[i]), 64'(exp_q[k].vs2[i]));
        check_val({where, " woffset"}, 64'(got_q[k].wo[i]), 64'(exp_q[k].wo[i]));
        check_val({where, " wen"}, 64'(got_q[k].wen[i]), 64'(exp_q[k].wen[i]));
      end
      check_val($sformatf("entry %0d pair %0d issue_last", idx, k),
                64'(got_q[k].last), 64'(exp_q[k].last));
    end
  endtask

  task automatic run_entry(input entry_t t, input int idx);
    int n_seen;
    build_expected(t);
    got_q.delete();
    ready_at_last = 1'b0;
    wait_ready();
    vl           = t.vl;
    vstart       = t.vstart;
    vs2_src      = t.vs2_src;
    vd_src       = t.vd_src;
    xs1          = t.xs1;
    imm5         = t.imm5;
    masked       = t.masked;
    mask_word    = t.mask_word;
    is_store     = t.is_store;
    hold_credits = (t.mode == MODE_HOLD);
    start        = 1'b1;
    @(posedge CLK);
    #1;
    start = 1'b0;
    if (t.mode == MODE_FLUSH) begin
      wait_pairs(3, 100);
      flush = 1'b1;
      @(posedge CLK);
      #1;
      flush  = 1'b0;
      n_seen = got_q.size();
      check_val("ready after flush", 64'(ready), 64'd1);
      check_val("issue_valid after flush", 64'(issue_valid), 64'd0);
      repeat (6) @(posedge CLK);
      #1;
      check_val("pairs issued after flush", 64'(got_q.size()), 64'(n_seen));
      if (n_seen >= exp_q.size()) fail_stop("flush did not cut the instruction short");
    end else begin
      if (t.mode == MODE_HOLD) begin
        wait_pairs(`VDEC_CREDITS, 100);
        repeat (8) @(posedge CLK);
        #1;
        check_val("pairs under held credits", 64'(got_q.size()), 64'(`VDEC_CREDITS));
        check_val("issue_valid under held credits", 64'(issue_valid), 64'd0);
        hold_credits = 1'b0;
      end
      wait_pairs(exp_q.size(), 200);
      check_val("ready with the last pair", 64'(ready_at_last), 64'd1);
    end
    drain_credits();
    if (t.mode != MODE_FLUSH) begin
      check_val($sformatf("entry %0d pair count", idx), 64'(got_q.size()), 64'(exp_q.size()));
    end
    compare_pairs(idx, got_q.size());
  endtask

  initial begin
    int idx;
    seed      = $urandom(16);
    CLK       = 1'b0;
    nRST      = 1'b0;
    flush     = 1'b0;
    start     = 1'b0;
    vl        = '0;
    vstart    = '0;
    vs2_src   = VS2_SRC_NORMAL;
    vd_src    = VD_SRC_NORMAL;
    xs1       = '0;
    imm5      = '0;
    masked    = 1'b0;
    mask_word = '0;
    is_store  = 1'b0;

    // vl, vstart, vs2 source, vd source, xs1, imm5, masked, mask_word, is_store, mode
    add_entry(7,  0,  VS2_SRC_NORMAL,   VD_SRC_NORMAL,   'h0,         0,  0, 'h0,         0, 0);
    add_entry(10, 2,  VS2_SRC_PLUS_XS1, VD_SRC_PLUS_XS1, 'h3c,        0,  0, 'h0,         0, 0);
    add_entry(9,  0,  VS2_SRC_MINUS_1,  VD_SRC_PLUS_IMM, 'h0,         31, 0, 'h0,         0, 0);
    add_entry(6,  1,  VS2_SRC_PLUS_IMM, VD_SRC_PLUS_1,   'h0,         5,  0, 'h0,         0, 0);
    add_entry(8,  0,  VS2_SRC_PLUS_1,   VD_SRC_ZERO,     'h0,         0,  0, 'h0,         0, 0);
    add_entry(5,  0,  VS2_SRC_XS1,      VD_SRC_NORMAL,   'h1234_5677, 0,  0, 'h0,         0, 0);
    add_entry(4,  0,  VS2_SRC_IMM,      VD_SRC_PLUS_IMM, 'h0,         17, 0, 'h0,         0, 0);
    add_entry(16, 3,  VS2_SRC_ZERO,     VD_SRC_NORMAL,   'h0,         0,  1, 'ha5c3_0f69, 0, 0);
    add_entry(12, 0,  VS2_SRC_NORMAL,   VD_SRC_NORMAL,   'h0,         0,  0, 'h0,         1, 0);
    add_entry(5,  5,  VS2_SRC_NORMAL,   VD_SRC_NORMAL,   'h0,         0,  0, 'h0,         0, 0);
    add_entry(3,  9,  VS2_SRC_PLUS_1,   VD_SRC_PLUS_1,   'h0,         0,  1, 'hffff_ffff, 0, 0);
    add_entry(20, 0,  VS2_SRC_NORMAL,   VD_SRC_NORMAL,   'h0,         0,  0, 'h0,         0, 1);
    add_entry(30, 0,  VS2_SRC_PLUS_XS1, VD_SRC_NORMAL,   'h5,         0,  0, 'h0,         0, 2);
    add_entry(11, 1,  VS2_SRC_MINUS_1,  VD_SRC_PLUS_XS1, 'hffff_fffe, 0,  1, 'h0f0f_3c3c, 0, 0);
    add_entry(63, 58, VS2_SRC_PLUS_1,   VD_SRC_PLUS_XS1, 'h7,         0,  0, 'h0,         0, 0);

    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_val("ready after reset", 64'(ready), 64'd1);
    check_val("issue_valid after reset", 64'(issue_valid), 64'd0);
    check_val("wen after reset", 64'(wen), 64'd0);

    for (idx = 0; idx < instr_tbl.size(); idx++) begin
      run_entry(instr_tbl[idx], idx);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== source/decode_issue_reg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue register toward execute, all lanes in one bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

module decode_issue_reg import vdec_pkg::*; (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           flush,
  input  logic                           emit,
  input  logic                           emit_last,
  input  offset_t [`VDEC_LANES-1:0]      lane_vs1,
  input  offset_t [`VDEC_LANES-1:0]      lane_vs2,
  input  offset_t [`VDEC_LANES-1:0]      lane_wo,
  input  logic    [`VDEC_LANES-1:0]      lane_wen,
  output logic                           issue_valid,
  output logic                           issue_last,
  output offset_t [`VDEC_LANES-1:0]      vs1_offset,
  output offset_t [`VDEC_LANES-1:0]      vs2_offset,
  output offset_t [`VDEC_LANES-1:0]      woffset,
  output logic    [`VDEC_LANES-1:0]      wen
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      vs1_offset  <= '0;
      vs2_offset  <= '0;
      woffset     <= '0;
      wen         <= '0;
    end else if (flush) begin
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      vs1_offset  <= '0;
      vs2_offset  <= '0;
      woffset     <= '0;
      wen         <= '0;
    end else if (emit) begin
      issue_valid <= 1'b1;
      issue_last  <= emit_last;
      vs1_offset  <= lane_vs1;
      vs2_offset  <= lane_vs2;
      woffset     <= lane_wo;
      wen         <= lane_wen;
    end else begin
      // bubble: offsets keep their old value, nothing is written
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      wen         <= '0;
    end
  end

endmodule

// ==== source/element_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// element pair sequencer with execute credit counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

module element_sequencer import vdec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  logic    flush,
  input  logic    credit_return,
  input  offset_t vl,
  input  offset_t vstart,
  output logic    ready,
  output logic    emit,
  output logic    emit_last,
  output offset_t base
);

  seq_state_t state, next_state;
  offset_t    next_base;
  credit_t    credits, next_credits;

  // one extra bit so the end test cannot wrap
  logic [`VDEC_OFF_W:0] base_end;

  assign ready = (state == IDLE);

  // a pair leaves whenever running with a free execute slot;
  // held off during flush so no credit is spent on a dropped pair
  assign emit = (state == RUN) && (credits != '0) && !flush;

  // also covers vstart >= vl, since base starts at vstart
  assign base_end  = {1'b0, base} + (`VDEC_OFF_W+1)'(`VDEC_LANES);
  assign emit_last = (base_end >= {1'b0, vl});

  always_comb begin
    next_state = state;
    next_base  = base;
    if (flush) begin
      next_state = IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            next_state = RUN;
            next_base  = vstart;
          end
        end
        RUN: begin
          if (emit) begin
            if (emit_last) begin
              next_state = IDLE;
            end else begin
              next_base = base + offset_t'(`VDEC_LANES);
            end
          end
        end
        default: next_state = IDLE;
      endcase
    end
  end

  // slot taken on emit, slot freed on return
  always_comb begin
    case ({emit, credit_return})
      2'b10:   next_credits = credits - credit_t'(1);
      2'b01:   next_credits = credits + credit_t'(1);
      default: next_credits = credits;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      base    <= '0;
      credits <= credit_t'(`VDEC_CREDITS);
    end else begin
      state   <= next_state;
      base    <= next_base;
      credits <= next_credits;
    end
  end

endmodule

// ==== source/lane_offset_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per lane operand and write offsets, mask bit select
// and write enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

module lane_offset_gen import vdec_pkg::*; #(
  parameter int LANE = 0
) (
  input  offset_t  base,
  input  offset_t  vl,
  input  vs2_src_t vs2_src,
  input  vd_src_t  vd_src,
  input  word_t    xs1,
  input  imm5_t    imm5,
  input  logic     masked,
  input  logic     is_store,
  input  word_t    mask_word,
  output offset_t  vs1_offset,
  output offset_t  vs2_offset,
  output offset_t  woffset,
  output logic     wen
);

  localparam int MIDX_W = $clog2(`VDEC_XLEN);

  logic [`VDEC_OFF_W:0] elem_wide;
  offset_t              elem;
  offset_t              xs1_off;
  offset_t              imm_off;
  logic                 lane_valid;
  logic                 mask_bit;

  assign elem_wide  = {1'b0, base} + (`VDEC_OFF_W+1)'(LANE);
  assign elem       = elem_wide[`VDEC_OFF_W-1:0];
  assign lane_valid = (elem_wide < {1'b0, vl});

  // scalar truncated, immediate zero extended
  assign xs1_off = xs1[`VDEC_OFF_W-1:0];
  assign imm_off = offset_t'(imm5);

  assign vs1_offset = elem;

  always_comb begin
    case (vs2_src)
      VS2_SRC_NORMAL:   vs2_offset = elem;
      VS2_SRC_PLUS_XS1: vs2_offset = elem + xs1_off;
      VS2_SRC_PLUS_IMM: vs2_offset = elem + imm_off;
      VS2_SRC_PLUS_1:   vs2_offset = elem + offset_t'(1);
      VS2_SRC_MINUS_1:  vs2_offset = elem - offset_t'(1);
      VS2_SRC_XS1:      vs2_offset = xs1_off;
      VS2_SRC_IMM:      vs2_offset = imm_off;
      default:          vs2_offset = '0;
    endcase
  end

  always_comb begin
    case (vd_src)
      VD_SRC_NORMAL:   woffset = elem;
      VD_SRC_PLUS_XS1: woffset = elem + xs1_off;
      VD_SRC_PLUS_IMM: woffset = elem + imm_off;
      VD_SRC_PLUS_1:   woffset = elem + offset_t'(1);
      default:         woffset = '0;
    endcase
  end

  // valid elements sit below vl, so the low bits index the mask
  assign mask_bit = mask_word[elem[MIDX_W-1:0]];

  assign wen = lane_valid && !is_store && (!masked || mask_bit);

endmodule

// ==== source/vdec_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane count, data widths and execute credit depth
// for the vector decode element sequencing stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VDEC_DEFS_SVH
`define VDEC_DEFS_SVH

// elements handled per cycle
`define VDEC_LANES 2

// scalar operand and mask word width
`define VDEC_XLEN 32

// element offset width, offsets wrap modulo 64
`define VDEC_OFF_W 6

// execute side buffer slots
`define VDEC_CREDITS 4

`endif

// ==== source/vdec_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector decode types: operand, offset, credit and
// immediate vectors, offset source and sequencer enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

package vdec_pkg;

  typedef logic [`VDEC_XLEN-1:0]  word_t;
  typedef logic [`VDEC_OFF_W-1:0] offset_t;
  typedef logic [2:0]             credit_t;
  typedef logic [4:0]             imm5_t;

  // gather / slide operand offset sources
  typedef enum logic [3:0] {
    VS2_SRC_NORMAL   = 4'd0,
    VS2_SRC_PLUS_XS1 = 4'd1,
    VS2_SRC_PLUS_IMM = 4'd2,
    VS2_SRC_PLUS_1   = 4'd3,
    VS2_SRC_MINUS_1  = 4'd4,
    VS2_SRC_XS1      = 4'd5,
    VS2_SRC_IMM      = 4'd6,
    VS2_SRC_ZERO     = 4'd7
  } vs2_src_t;

  // destination write offset sources
  typedef enum logic [2:0] {
    VD_SRC_NORMAL   = 3'd0,
    VD_SRC_ZERO     = 3'd1,
    VD_SRC_PLUS_XS1 = 3'd2,
    VD_SRC_PLUS_IMM = 3'd3,
    VD_SRC_PLUS_1   = 3'd4
  } vd_src_t;

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } seq_state_t;

endpackage

// ==== source/vector_decode_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector decode stage top: sequencer, lanes, issue register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdec_defs.svh"

module vector_decode_stage import vdec_pkg::*; (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      flush,
  input  logic                      start,
  input  logic                      credit_return,
  input  offset_t                   vl,
  input  offset_t                   vstart,
  input  vs2_src_t                  vs2_src,
  input  vd_src_t                   vd_src,
  input  word_t                     xs1,
  input  imm5_t                     imm5,
  input  logic                      masked,
  input  word_t                     mask_word,
  input  logic                      is_store,
  output logic                      ready,
  output logic                      issue_valid,
  output logic                      issue_last,
  output offset_t [`VDEC_LANES-1:0] vs1_offset,
  output offset_t [`VDEC_LANES-1:0] vs2_offset,
  output offset_t [`VDEC_LANES-1:0] woffset,
  output logic    [`VDEC_LANES-1:0] wen
);

  logic                      emit;
  logic                      emit_last;
  offset_t                   base;
  offset_t [`VDEC_LANES-1:0] lane_vs1;
  offset_t [`VDEC_LANES-1:0] lane_vs2;
  offset_t [`VDEC_LANES-1:0] lane_wo;
  logic    [`VDEC_LANES-1:0] lane_wen;

  element_sequencer u_seq (
    .CLK(CLK), .nRST(nRST), .start(start), .flush(flush),
    .credit_return(credit_return), .vl(vl), .vstart(vstart),
    .ready(ready), .emit(emit), .emit_last(emit_last), .base(base)
  );

  // one offset generator per lane, element = base + lane
  for (genvar i = 0; i < `VDEC_LANES; i++) begin : g_lane
    lane_offset_gen #(.LANE(i)) u_lane (
      .base(base), .vl(vl), .vs2_src(vs2_src), .vd_src(vd_src),
      .xs1(xs1), .imm5(imm5), .masked(masked), .is_store(is_store),
      .mask_word(mask_word), .vs1_offset(lane_vs1[i]),
      .vs2_offset(lane_vs2[i]), .woffset(lane_wo[i]), .wen(lane_wen[i])
    );
  end

  decode_issue_reg u_issue (
    .CLK(CLK), .nRST(nRST), .flush(flush), .emit(emit), .emit_last(emit_last),
    .lane_vs1(lane_vs1), .lane_vs2(lane_vs2), .lane_wo(lane_wo),
    .lane_wen(lane_wen), .issue_valid(issue_valid), .issue_last(issue_last),
    .vs1_offset(vs1_offset), .vs2_offset(vs2_offset), .woffset(woffset),
    .wen(wen)
  );

endmodule
